/* rtl/issue_defs.svh */
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

//////////////////////////////////////////////////
// datapath widths
//////////////////////////////////////////////////

`define INST_WIDTH      32 // instruction word.
`define ADDR_WIDTH      32 // pc.
`define ID_WIDTH        6  // instruction id.
`define REG_ADDR_WIDTH  5  // 32 registers.

`define QUEUE_DEPTH     8
`define FREE_WIDTH      4  // holds 0 to QUEUE_DEPTH.

//////////////////////////////////////////////////
// instruction fields
//////////////////////////////////////////////////

`define OPCODE_MSB      31
`define OPCODE_LSB      26
`define RS_MSB          25
`define RS_LSB          21
`define RT_MSB          20
`define RT_LSB          16
`define RD_MSB          15
`define RD_LSB          11

`endif

/* rtl/issue_pkg.sv */
`include "issue_defs.svh"

package issue_pkg;

  // top two bits select the group.
  typedef enum logic [5:0] {
    NOP   = 6'h00, // register alu group.
    JR    = 6'h01,
    ADD   = 6'h02,
    SUB   = 6'h03,
    CMP   = 6'h04,
    TEST  = 6'h05,
    ADDI  = 6'h10, // immediate alu group.
    SUBI  = 6'h11,
    CMPI  = 6'h12,
    TESTI = 6'h13,
    LW    = 6'h20, // memory group.
    SW    = 6'h21,
    JMP   = 6'h30, // jump group.
    JE    = 6'h31
  } opcode_e;

  typedef enum logic [1:0] {
    PIPE_ALU,
    PIPE_MEMORY,
    PIPE_BRANCH
  } pipe_e;

  typedef struct packed {
    logic [`ID_WIDTH-1:0]   id;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`INST_WIDTH-1:0] instruction;
  } queue_entry_t;

  typedef struct packed {
    logic [`REG_ADDR_WIDTH-1:0] src0;
    logic [`REG_ADDR_WIDTH-1:0] src1;
    logic [`REG_ADDR_WIDTH-1:0] dest;
    logic                       use_src0;
    logic                       use_src1;
    logic                       use_dest;
  } reg_use_t;

  typedef struct packed {
    logic                       valid;
    logic [`REG_ADDR_WIDTH-1:0] dest; // load target not yet written.
  } load_ahead_t;

  typedef struct packed {
    logic         valid;
    queue_entry_t entry;
  } issue_slot_t;

endpackage

/* rtl/issue_queue.sv */
`timescale 1ns/100ps

`include "issue_defs.svh"

module issue_queue (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    flush,
  input  logic                    push0,
  input  logic                    push1,
  input  issue_pkg::queue_entry_t push_data0,
  input  issue_pkg::queue_entry_t push_data1,
  input  logic                    pop0,
  input  logic                    pop1,
  output issue_pkg::queue_entry_t head0,
  output issue_pkg::queue_entry_t head1,
  output logic [1:0]              head_valid,
  output logic [`FREE_WIDTH-1:0]  free,
  output logic                    stall
);

  issue_pkg::queue_entry_t entries      [`QUEUE_DEPTH];
  issue_pkg::queue_entry_t entries_next [`QUEUE_DEPTH];

  logic [`FREE_WIDTH-1:0] count;
  logic [`FREE_WIDTH-1:0] count_next;
  logic [`FREE_WIDTH-1:0] pop_num;
  logic [`FREE_WIDTH-1:0] base; // first empty slot after the pop.
  logic                   accept0;
  logic                   accept1;

  assign free  = `FREE_WIDTH'(`QUEUE_DEPTH) - count;
  assign stall = free < `FREE_WIDTH'(2);

  assign accept0 = push0 && !stall && !flush;
  assign accept1 = push1 && !stall && !flush;

  assign pop_num = `FREE_WIDTH'(pop0) + `FREE_WIDTH'(pop1);

  //////////////////////////////////////////////////
  // compact then append
  //////////////////////////////////////////////////

  always_comb begin
    base       = count - pop_num;
    count_next = base + `FREE_WIDTH'(accept0) + `FREE_WIDTH'(accept1);
    for (int i = 0; i < `QUEUE_DEPTH; i++) begin
      entries_next[i] = entries[i];
      if (pop1) begin
        if (i + 2 < `QUEUE_DEPTH) begin
          entries_next[i] = entries[(i + 2) % `QUEUE_DEPTH];
        end
      end else if (pop0) begin
        if (i + 1 < `QUEUE_DEPTH) begin
          entries_next[i] = entries[(i + 1) % `QUEUE_DEPTH];
        end
      end
      if (accept0 && i == base) begin
        entries_next[i] = push_data0;
      end
      if (accept1 && i == base + `FREE_WIDTH'(accept0)) begin
        entries_next[i] = push_data1; // lands behind push0 when both push.
      end
    end
    if (flush) begin
      count_next = '0;
    end
  end

  always_ff @(posedge clk) begin
    entries <= entries_next;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

  //////////////////////////////////////////////////
  // head view
  //////////////////////////////////////////////////

  assign head_valid[0] = count != '0;
  assign head_valid[1] = count > `FREE_WIDTH'(1);

  // empty slots read as nop.
  assign head0 = head_valid[0] ? entries[0] : '0;
  assign head1 = head_valid[1] ? entries[1] : '0;

endmodule

/* rtl/reg_depends.sv */
`timescale 1ns/100ps

`include "issue_defs.svh"

module reg_depends
  import issue_pkg::*;
(
  input  logic [`INST_WIDTH-1:0] instruction,
  output reg_use_t               reg_use
);

  opcode_e                    opcode;
  logic [`REG_ADDR_WIDTH-1:0] rs;
  logic [`REG_ADDR_WIDTH-1:0] rt;
  logic [`REG_ADDR_WIDTH-1:0] rd;

  assign opcode = opcode_e'(instruction[`OPCODE_MSB:`OPCODE_LSB]);
  assign rs     = instruction[`RS_MSB:`RS_LSB];
  assign rt     = instruction[`RT_MSB:`RT_LSB];
  assign rd     = instruction[`RD_MSB:`RD_LSB];

  always_comb begin
    reg_use = '0;
    case (opcode[5:4])
      2'b00: begin
        if (opcode == JR) begin
          reg_use.src0     = rs;
          reg_use.use_src0 = 1'b1;
        end else if (opcode != NOP) begin
          reg_use = '{src0: rs, src1: rt, dest: rd,
                      use_src0: 1'b1, use_src1: 1'b1, use_dest: 1'b1};
        end
      end
      2'b01: begin
        reg_use = '{src0: rs, src1: '0, dest: rt,
                    use_src0: 1'b1, use_src1: 1'b0, use_dest: 1'b1};
      end
      2'b10: begin
        if (opcode == LW) begin
          reg_use = '{src0: rs, src1: '0, dest: rt,
                      use_src0: 1'b1, use_src1: 1'b0, use_dest: 1'b1};
        end else if (opcode == SW) begin
          reg_use = '{src0: rs, src1: rt, dest: '0,
                      use_src0: 1'b1, use_src1: 1'b1, use_dest: 1'b0};
        end
      end
      2'b11: reg_use = '0; // jumps read nothing.
    endcase
  end

endmodule

/* rtl/pair_hazard.sv */
`timescale 1ns/100ps

module pair_hazard
  import issue_pkg::*;
(
  input  logic [1:0]  entry_valid,
  input  reg_use_t    use0,
  input  reg_use_t    use1,
  input  load_ahead_t load_ahead,
  output logic [1:0]  issue_mask
);

  logic load_hit;
  logic split_hit;

  function automatic logic reads_reg(reg_use_t use_in, logic [4:0] reg_addr);
    return (use_in.use_src0 && use_in.src0 == reg_addr) ||
           (use_in.use_src1 && use_in.src1 == reg_addr);
  endfunction

  // load result arrives too late for either head entry.
  assign load_hit = load_ahead.valid &&
                    (reads_reg(use0, load_ahead.dest) || reads_reg(use1, load_ahead.dest));

  // entry 1 needs what entry 0 writes.
  assign split_hit = use0.use_dest && reads_reg(use1, use0.dest);

  always_comb begin
    issue_mask = entry_valid;
    if (load_hit) begin
      issue_mask = 2'b00;
    end else if (split_hit) begin
      issue_mask[1] = 1'b0;
    end
  end

endmodule

/* rtl/pipe_steer.sv */
`timescale 1ns/100ps

module pipe_steer
  import issue_pkg::*;
(
  input  opcode_e    opcode0,
  input  opcode_e    opcode1,
  input  logic [1:0] mask_in,
  output logic [1:0] mask_out,
  output logic       first
);

  pipe_e pipe0;
  pipe_e pipe1;

  function automatic pipe_e pipe_of(opcode_e op);
    pipe_e pipe;
    case (op[5:4])
      2'b00: begin
        pipe = (op == CMP || op == TEST) ? PIPE_BRANCH : PIPE_ALU;
      end
      2'b01: begin
        pipe = (op == CMPI || op == TESTI) ? PIPE_BRANCH : PIPE_ALU;
      end
      2'b10:   pipe = PIPE_MEMORY;
      default: pipe = PIPE_BRANCH; // jump group.
    endcase
    return pipe;
  endfunction

  assign pipe0 = pipe_of(opcode0);
  assign pipe1 = pipe_of(opcode1);

  //////////////////////////////////////////////////
  // port 0 takes branch, port 1 takes memory
  //////////////////////////////////////////////////

  always_comb begin
    mask_out = mask_in;
    first    = 1'b0;
    case ({pipe0, pipe1})
      {PIPE_BRANCH, PIPE_BRANCH}: begin
        mask_out = mask_in & 2'b01; // one branch unit.
      end
      {PIPE_MEMORY, PIPE_MEMORY}: begin
        mask_out = mask_in & 2'b01;
        first    = 1'b1;
      end
      {PIPE_MEMORY, PIPE_BRANCH},
      {PIPE_MEMORY, PIPE_ALU},
      {PIPE_ALU, PIPE_BRANCH}: begin
        first = 1'b1;
      end
      default: first = 1'b0;
    endcase
  end

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/100ps

`include "issue_defs.svh"

module issue_stage
  import issue_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   flush,
  input  logic                   push0,
  input  logic                   push1,
  input  queue_entry_t           push_data0,
  input  queue_entry_t           push_data1,
  input  load_ahead_t            load_ahead,
  output logic                   stall,
  output logic [`FREE_WIDTH-1:0] free,
  output issue_slot_t            issue0,
  output issue_slot_t            issue1,
  output logic                   first
);

  queue_entry_t head0;
  queue_entry_t head1;
  logic [1:0]   head_valid;
  reg_use_t     use0;
  reg_use_t     use1;
  logic [1:0]   hazard_mask;
  logic [1:0]   issue_mask;
  issue_slot_t  slot0;
  issue_slot_t  slot1;

  issue_queue i_queue (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .push0      (push0),
    .push1      (push1),
    .push_data0 (push_data0),
    .push_data1 (push_data1),
    .pop0       (issue_mask[0]),
    .pop1       (issue_mask[1]),
    .head0      (head0),
    .head1      (head1),
    .head_valid (head_valid),
    .free       (free),
    .stall      (stall)
  );

  reg_depends i_depends0 (
    .instruction (head0.instruction),
    .reg_use     (use0)
  );

  reg_depends i_depends1 (
    .instruction (head1.instruction),
    .reg_use     (use1)
  );

  pair_hazard i_hazard (
    .entry_valid (head_valid),
    .use0        (use0),
    .use1        (use1),
    .load_ahead  (load_ahead),
    .issue_mask  (hazard_mask)
  );

  pipe_steer i_steer (
    .opcode0  (opcode_e'(head0.instruction[`OPCODE_MSB:`OPCODE_LSB])),
    .opcode1  (opcode_e'(head1.instruction[`OPCODE_MSB:`OPCODE_LSB])),
    .mask_in  (hazard_mask),
    .mask_out (issue_mask),
    .first    (first)
  );

  //////////////////////////////////////////////////
  // slot build and lane swap
  //////////////////////////////////////////////////

  always_comb begin
    slot0 = '0;
    slot1 = '0;
    if (!flush) begin
      if (issue_mask[0]) begin
        slot0 = '{valid: 1'b1, entry: head0};
      end
      if (issue_mask[1]) begin
        slot1 = '{valid: 1'b1, entry: head1};
      end
    end
    issue0 = first ? slot1 : slot0;
    issue1 = first ? slot0 : slot1; // entry 0 moves to port 1 on swap.
  end

endmodule

/* dv/tb_issue_stage.sv */
`timescale 1ns/100ps

`include "issue_defs.svh"

module tb_issue_stage
  import issue_pkg::*;
();

  logic                   clk;
  logic                   arst_n;
  logic                   flush;
  logic                   push0;
  logic                   push1;
  queue_entry_t           push_data0;
  queue_entry_t           push_data1;
  load_ahead_t            load_ahead;
  logic                   stall;
  logic [`FREE_WIDTH-1:0] free;
  issue_slot_t            issue0;
  issue_slot_t            issue1;
  logic                   first;

  queue_entry_t model_q[$]; // entries the DUT should hold.
  issue_slot_t  seen0;
  issue_slot_t  seen1;
  logic         seen_first;
  int           errors = 0;
  int           cycles = 0;

  issue_stage i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= 2000) begin
      $display("timeout: run stopped after %0d cycles", cycles);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////

  // 0 alu, 1 memory, 2 branch.
  function automatic int class_of(logic [5:0] op);
    if (op[5:4] == 2'b10) begin
      return 1;
    end
    if (op[5:4] == 2'b11 || op inside {CMP, TEST, CMPI, TESTI}) begin
      return 2;
    end
    return 0;
  endfunction

  function automatic reg_use_t regs_of(logic [31:0] inst);
    reg_use_t u;
    u = '{src0: inst[25:21], src1: inst[20:16], dest: inst[15:11],
          use_src0: 1'b0, use_src1: 1'b0, use_dest: 1'b0};
    if (inst[31:26] == JR) begin
      u.use_src0 = 1'b1;
    end else if (inst[31:26] inside {ADD, SUB, CMP, TEST}) begin
      {u.use_src0, u.use_src1, u.use_dest} = 3'b111;
    end else if (inst[31:26] inside {ADDI, SUBI, CMPI, TESTI, LW}) begin
      u.dest = inst[20:16]; // rt is the target here.
      {u.use_src0, u.use_src1, u.use_dest} = 3'b101;
    end else if (inst[31:26] == SW) begin
      {u.use_src0, u.use_src1, u.use_dest} = 3'b110;
    end
    return u;
  endfunction

  function automatic logic uses_reg(reg_use_t u, logic [4:0] r);
    return (u.use_src0 && u.src0 == r) || (u.use_src1 && u.src1 == r);
  endfunction

  function automatic queue_entry_t make_entry(opcode_e op, int rs, int rt, int rd);
    queue_entry_t e;
    e.id          = `ID_WIDTH'($urandom());
    e.pc          = `ADDR_WIDTH'($urandom());
    e.instruction = {op, 5'(rs), 5'(rt), 5'(rd), 11'h000};
    return e;
  endfunction

  // drive on the falling edge, check mid cycle, then advance the model.
  task automatic run_cycle(input logic p0, input queue_entry_t d0, input logic p1,
                           input queue_entry_t d1, input load_ahead_t la, input logic fl);
    queue_entry_t h0;
    queue_entry_t h1;
    reg_use_t     u0;
    reg_use_t     u1;
    logic [1:0]   mask;
    logic         swap;
    int           n;
    issue_slot_t  e0;
    issue_slot_t  e1;
    @(negedge clk);
    push0      = p0;
    push_data0 = d0;
    push1      = p1;
    push_data1 = d1;
    load_ahead = la;
    flush      = fl;
    #25;
    n    = model_q.size();
    h0   = (n > 0) ? model_q[0] : '0;
    h1   = (n > 1) ? model_q[1] : '0;
    u0   = regs_of(h0.instruction);
    u1   = regs_of(h1.instruction);
    mask = {n > 1, n > 0};
    if (la.valid && (uses_reg(u0, la.dest) || uses_reg(u1, la.dest))) begin
      mask = 2'b00;
    end else if (u0.use_dest && uses_reg(u1, u0.dest)) begin
      mask[1] = 1'b0;
    end
    if (class_of(h0.instruction[31:26]) == class_of(h1.instruction[31:26]) &&
        class_of(h0.instruction[31:26]) != 0) begin
      mask[1] = 1'b0; // one unit per class.
    end
    swap = class_of(h0.instruction[31:26]) == 1 ||
           (class_of(h0.instruction[31:26]) == 0 && class_of(h1.instruction[31:26]) == 2);
    e0 = '0;
    e1 = '0;
    if (!fl && mask[0]) begin
      e0 = {1'b1, h0};
    end
    if (!fl && mask[1]) begin
      e1 = {1'b1, h1};
    end
    if (swap) begin
      {e0, e1} = {e1, e0};
    end
    assert (issue0 === e0 && issue1 === e1) else begin
      errors++;
      $display("FAIL %0t: ports %h %h, expected %h %h", $time, issue0, issue1, e0, e1);
    end
    assert (fl || first === swap) else begin
      errors++;
      $display("FAIL %0t: first %b, expected %b", $time, first, swap);
    end
    assert (free === `FREE_WIDTH'(`QUEUE_DEPTH - n) && stall === (`QUEUE_DEPTH - n < 2)) else begin
      errors++;
      $display("FAIL %0t: free %0d stall %b with %0d entries", $time, free, stall, n);
    end
    seen0      = issue0;
    seen1      = issue1;
    seen_first = first;
    if (fl) begin
      model_q.delete();
    end else begin
      repeat (int'(mask[0]) + int'(mask[1])) void'(model_q.pop_front());
      if (`QUEUE_DEPTH - n >= 2) begin
        if (p0) model_q.push_back(d0);
        if (p1) model_q.push_back(d1);
      end
    end
  endtask

  task automatic push_pair(input queue_entry_t a, input queue_entry_t b, input load_ahead_t la);
    run_cycle(1'b1, a, 1'b1, b, la, 1'b0);
  endtask

  task automatic idle_cycle(input load_ahead_t la);
    run_cycle(1'b0, '0, 1'b0, '0, la, 1'b0);
  endtask

  task automatic expect_seen(input logic v0, input logic v1, input logic f, input string what);
    assert (seen0.valid === v0 && seen1.valid === v1 && seen_first === f) else begin
      errors++;
      $display("FAIL %0t: %s, valids %b%b first %b", $time, what, seen0.valid, seen1.valid,
               seen_first);
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic pair_after_reset();
    queue_entry_t a;
    queue_entry_t b;
    assert (free === 8 && !stall && !issue0.valid && !issue1.valid) else begin
      errors++;
      $display("FAIL %0t: state after reset", $time);
    end
    a = make_entry(ADD, 1, 2, 3);
    b = make_entry(ADD, 4, 6, 7);
    push_pair(a, b, '0);
    idle_cycle('0);
    expect_seen(1'b1, 1'b1, 1'b0, "independent adds");
    assert (seen0.entry === a && seen1.entry === b) else begin
      errors++;
      $display("FAIL %0t: adds carry wrong pc or id", $time);
    end
    idle_cycle('0);
  endtask

  task automatic load_use();
    load_ahead_t la;
    la = '{valid: 1'b1, dest: 5'd9};
    push_pair(make_entry(ADD, 9, 2, 3), make_entry(SUB, 4, 5, 6), la);
    idle_cycle(la);
    expect_seen(1'b0, 1'b0, 1'b0, "load-use blocks both");
    assert (free === 6) else begin
      errors++;
      $display("FAIL %0t: free %0d during load-use", $time, free);
    end
    idle_cycle('0);
    expect_seen(1'b1, 1'b1, 1'b0, "pair after load");
  endtask

  task automatic split_pair();
    queue_entry_t a;
    queue_entry_t b;
    a = make_entry(ADD, 1, 2, 5);
    b = make_entry(SUB, 5, 3, 4); // reads r5 from the add.
    push_pair(a, b, '0);
    idle_cycle('0);
    expect_seen(1'b1, 1'b0, 1'b0, "split keeps add only");
    idle_cycle('0);
    expect_seen(1'b1, 1'b0, 1'b0, "sub alone");
    assert (seen0.entry === b) else begin
      errors++;
      $display("FAIL %0t: sub not on port 0", $time);
    end
  endtask

  task automatic steering();
    queue_entry_t a;
    queue_entry_t b;
    a = make_entry(LW, 1, 8, 0);
    b = make_entry(ADD, 2, 3, 4);
    push_pair(a, b, '0);
    idle_cycle('0);
    expect_seen(1'b1, 1'b1, 1'b1, "load and add swap");
    assert (seen1.entry === a && seen0.entry === b) else begin
      errors++;
      $display("FAIL %0t: load not on port 1", $time);
    end
    push_pair(make_entry(CMP, 1, 2, 0), make_entry(JE, 0, 0, 0), '0);
    idle_cycle('0);
    expect_seen(1'b1, 1'b0, 1'b0, "two branches");
    idle_cycle('0);
    push_pair(make_entry(LW, 1, 10, 0), make_entry(LW, 2, 11, 0), '0);
    idle_cycle('0);
    expect_seen(1'b0, 1'b1, 1'b1, "two loads");
    idle_cycle('0);
  endtask

  task automatic fill_queue();
    load_ahead_t la;
    la = '{valid: 1'b1, dest: 5'd1};
    repeat (5) push_pair(make_entry(ADD, 1, 2, 3), make_entry(ADD, 1, 2, 3), la);
    assert (stall === 1'b1 && free === 0) else begin
      errors++;
      $display("FAIL %0t: full queue shows free %0d stall %b", $time, free, stall);
    end
    idle_cycle(la);
    repeat (5) idle_cycle('0);
  endtask

  task automatic flush_queue();
    push_pair(make_entry(ADD, 1, 2, 3), make_entry(SUB, 4, 5, 6), '0);
    run_cycle(1'b0, '0, 1'b0, '0, '0, 1'b1);
    expect_seen(1'b0, 1'b0, 1'b0, "slots during flush");
    idle_cycle('0);
    assert (free === 8) else begin
      errors++;
      $display("FAIL %0t: free %0d after flush", $time, free);
    end
  endtask

  initial begin
    void'($urandom(32'h6a70b775));
    arst_n     = 1'b0;
    flush      = 1'b0;
    push0      = 1'b0;
    push1      = 1'b0;
    push_data0 = '0;
    push_data1 = '0;
    load_ahead = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    #25;
    pair_after_reset();
    load_use();
    split_pair();
    steering();
    fill_queue();
    flush_queue();
    $display("run complete: %0d errors in %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+rtl
rtl/issue_pkg.sv
rtl/issue_queue.sv
rtl/reg_depends.sv
rtl/pair_hazard.sv
rtl/pipe_steer.sv
rtl/issue_stage.sv
dv/tb_issue_stage.sv

/* Bender.yml */
package:
  name: issue_stage

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/issue_pkg.sv
      - rtl/issue_queue.sv
      - rtl/reg_depends.sv
      - rtl/pair_hazard.sv
      - rtl/pipe_steer.sv
      - rtl/issue_stage.sv
      - dv/tb_issue_stage.sv
